// File: rx_mac_pkg.sv
package rx_mac_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // xgmii column
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int xgmii_width = 32;
    localparam int xgmii_lanes = xgmii_width / 8;

    localparam logic [7:0] xgmii_idle      = 8'h07;
    localparam logic [7:0] xgmii_start     = 8'hfb;
    localparam logic [7:0] xgmii_terminate = 8'hfd;
    localparam logic [7:0] xgmii_error     = 8'hfe;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ethernet framing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hd5;

    localparam int preamble_len = 6;                // preamble bytes after the start character

    typedef logic [10:0] frame_len_t;               // byte count from the DA through the FCS

    localparam frame_len_t min_frame_len = 11'd64;
    localparam frame_len_t max_frame_len = 11'd1518;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // crc-32
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [31:0] crc_init      = 32'hffff_ffff;
    localparam logic [31:0] crc_poly_refl = 32'hedb8_8320;

    // register value once a correct FCS has gone through, no final inversion applied
    localparam logic [31:0] crc_residue   = 32'hdebb_20e3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decoded lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        lane_data,                                  // ctl low, plain data byte
        lane_term,                                  // terminate character
        lane_err,                                   // error or unknown control code
        lane_other                                  // idle or start
    } lane_kind_t;

endpackage

// File: xgmii_lane_decode.sv
`timescale 1ns/1ns

module xgmii_lane_decode (
    input  logic                               rx_clk,
    input  logic                               rx_rst,
    input  logic [rx_mac_pkg::xgmii_width-1:0] xgmii_data,
    input  logic [rx_mac_pkg::xgmii_lanes-1:0] xgmii_ctl,
    output logic                               dec_valid,
    output logic                               dec_start,
    output logic [rx_mac_pkg::xgmii_width-1:0] dec_data,
    output rx_mac_pkg::lane_kind_t             dec_kind [rx_mac_pkg::xgmii_lanes]
);
    import rx_mac_pkg::*;

    lane_kind_t kind_next [xgmii_lanes];
    logic       start_next;

    always_comb begin
        for (int i = 0; i < xgmii_lanes; i++) begin
            if (!xgmii_ctl[i]) begin
                kind_next[i] = lane_data;
            end else begin
                case (xgmii_data[8*i +: 8])
                    xgmii_terminate:         kind_next[i] = lane_term;
                    xgmii_error:             kind_next[i] = lane_err;
                    xgmii_idle, xgmii_start: kind_next[i] = lane_other;
                    default:                 kind_next[i] = lane_err;  // reserved codes count as errors
                endcase
            end
        end
    end

    // only lane 0 may open a frame
    assign start_next = xgmii_ctl[0] && xgmii_data[7:0] == xgmii_start;

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            dec_valid <= 1'b0;
            dec_start <= 1'b0;
        end else begin
            dec_valid <= 1'b1;                      // xgmii delivers a column on every edge
            dec_start <= start_next;
        end
    end

    always_ff @(posedge rx_clk) begin
        dec_data <= xgmii_data;
        dec_kind <= kind_next;
    end

endmodule

// File: eth_crc32.sv
`timescale 1ns/1ns

module eth_crc32 (
    input  logic                               rx_clk,
    input  logic                               rx_rst,
    input  logic                               crc_clear,
    input  logic                               crc_en,
    input  logic [rx_mac_pkg::xgmii_width-1:0] crc_data,
    input  logic [rx_mac_pkg::xgmii_lanes-1:0] crc_mask,
    output logic                               crc_ok
);
    import rx_mac_pkg::*;

    logic [31:0] crc_reg;
    logic [31:0] crc_next;

    // lane 0 is the earliest byte on the wire, so lanes fold in ascending order
    always_comb begin
        crc_next = crc_reg;
        for (int i = 0; i < xgmii_lanes; i++) begin
            if (crc_mask[i]) begin
                crc_next = crc_next ^ {24'd0, crc_data[8*i +: 8]};
                for (int b = 0; b < 8; b++) begin
                    if (crc_next[0]) begin
                        crc_next = (crc_next >> 1) ^ crc_poly_refl;
                    end else begin
                        crc_next = crc_next >> 1;
                    end
                end
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            crc_reg <= crc_init;
        end else if (crc_clear) begin
            crc_reg <= crc_init;
        end else if (crc_en) begin
            crc_reg <= crc_next;
        end
    end

    // the FCS goes through the same path as the data, so a good frame ends on the residue
    assign crc_ok = crc_reg == crc_residue;

    // valid bytes always start at lane 0 and never leave a gap
    assert property (@(posedge rx_clk) disable iff (!rx_rst)
        crc_en |-> crc_mask inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
        else $error("eth_crc32: crc_mask %b is not contiguous from lane 0", crc_mask);

endmodule

// File: rx_frame_fsm.sv
`timescale 1ns/1ns

module rx_frame_fsm (
    input  logic                               rx_clk,
    input  logic                               rx_rst,
    input  logic                               dec_valid,
    input  logic                               dec_start,
    input  logic [rx_mac_pkg::xgmii_width-1:0] dec_data,
    input  rx_mac_pkg::lane_kind_t             dec_kind [rx_mac_pkg::xgmii_lanes],
    input  logic                               crc_ok,
    input  logic                               overflow,
    output logic                               crc_clear,
    output logic                               crc_en,
    output logic [rx_mac_pkg::xgmii_width-1:0] crc_data,
    output logic [rx_mac_pkg::xgmii_lanes-1:0] crc_mask,
    output logic                               wr_en,
    output logic [rx_mac_pkg::xgmii_width-1:0] wr_data,
    output logic [rx_mac_pkg::xgmii_lanes-1:0] wr_keep,
    output logic                               wr_last,
    output logic                               commit,
    output logic                               discard,
    output logic                               frame_good,
    output logic                               frame_bad,
    output logic                               crc_error
);
    import rx_mac_pkg::*;

    localparam int sfd_lane = preamble_len - xgmii_lanes + 1;  // lane of the SFD in column two

    typedef enum logic [2:0] {st_idle, st_preamble, st_body, st_verdict, st_drop} state_t;

    state_t                 state;
    logic [xgmii_lanes-1:0] col_mask;
    logic [2:0]             col_bytes;
    logic                   run;
    logic                   col_term;
    logic                   col_bad;
    logic                   start_ok;
    logic                   pre_ok;
    logic                   bad_flag;
    logic                   too_long;
    logic                   formal_ok;
    frame_len_t             len;
    logic                   hold_valid;
    logic [xgmii_width-1:0] hold_data;
    logic [xgmii_lanes-1:0] hold_keep;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // column classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        run       = 1'b1;
        col_bytes = 3'd0;
        for (int i = 0; i < xgmii_lanes; i++) begin
            run         = run && dec_kind[i] == lane_data;
            col_mask[i] = run;
            col_bytes   = col_bytes + {2'b00, run};
        end
        col_term = !(&col_mask) && dec_kind[col_bytes[1:0]] == lane_term;
        col_bad  = !(&col_mask) && !col_term;    // error or stray control before any terminate
    end

    always_comb begin
        start_ok = 1'b1;
        for (int i = 1; i < xgmii_lanes; i++) begin
            start_ok &= dec_kind[i] == lane_data && dec_data[8*i +: 8] == preamble_byte;
        end
        pre_ok = dec_kind[sfd_lane] == lane_data && dec_data[8*sfd_lane +: 8] == sfd_byte;
        for (int i = 0; i < sfd_lane; i++) begin
            pre_ok &= dec_kind[i] == lane_data && dec_data[8*i +: 8] == preamble_byte;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            state      <= st_idle;
            bad_flag   <= 1'b0;
            too_long   <= 1'b0;
            len        <= '0;
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= state == st_body && !col_bad && col_bytes != 3'd0;
            case (state)
                st_idle, st_drop: begin
                    if (dec_valid && dec_start) begin
                        state    <= start_ok ? st_preamble : st_verdict;
                        bad_flag <= !start_ok;
                        too_long <= 1'b0;
                        len      <= '0;
                    end else if (col_bytes == 3'd0) begin
                        state <= st_idle;           // drop ends on the first column with no data
                    end
                end
                st_preamble: begin
                    state    <= pre_ok ? st_body : st_verdict;
                    bad_flag <= !pre_ok;
                end
                st_body: begin
                    if (!too_long) begin
                        len <= len + frame_len_t'(col_bytes);
                    end
                    too_long <= too_long || len + frame_len_t'(col_bytes) > max_frame_len;
                    if (col_bad) begin
                        state    <= st_verdict;
                        bad_flag <= 1'b1;
                    end else if (col_term) begin
                        state <= st_verdict;
                    end
                end
                st_verdict: state <= bad_flag ? st_drop : st_idle;  // a bad frame is still on the line
                default:    state <= st_idle;
            endcase
        end
    end

    // one word is held back so the last one can be tagged when the terminate sits in lane 0
    always_ff @(posedge rx_clk) begin
        if (state == st_body && col_bytes != 3'd0) begin
            hold_data <= dec_data;
            hold_keep <= col_mask;
        end
    end

    assign crc_clear = state == st_preamble;
    assign crc_en    = state == st_body;
    assign crc_data  = dec_data;
    assign crc_mask  = col_mask;

    assign wr_en   = hold_valid && (state == st_verdict || (state == st_body && !col_bad));
    assign wr_data = hold_data;
    assign wr_keep = hold_keep;
    assign wr_last = state == st_verdict || (state == st_body && col_term && col_bytes == 3'd0);

    assign formal_ok  = !bad_flag && !too_long && len >= min_frame_len;
    assign frame_good = state == st_verdict && formal_ok && crc_ok && !overflow;
    assign frame_bad  = state == st_verdict && !frame_good;
    assign crc_error  = state == st_verdict && formal_ok && !crc_ok;
    assign commit     = frame_good;
    assign discard    = frame_bad;

    // a frame is committed only once its last word has gone to the buffer
    assert property (@(posedge rx_clk) disable iff (!rx_rst)
        commit |-> !discard && ((wr_en && wr_last) || $past(wr_en && wr_last)))
        else $error("rx_frame_fsm: commit without a last word or together with discard");

endmodule

// File: rx_frame_buffer.sv
`timescale 1ns/1ns

module rx_frame_buffer #(
    parameter int buffer_depth = 512
) (
    input  logic                               rx_clk,
    input  logic                               rx_rst,
    input  logic                               wr_en,
    input  logic [rx_mac_pkg::xgmii_width-1:0] wr_data,
    input  logic [rx_mac_pkg::xgmii_lanes-1:0] wr_keep,
    input  logic                               wr_last,
    input  logic                               commit,
    input  logic                               discard,
    input  logic                               m_ready,
    output logic                               overflow,
    output logic [rx_mac_pkg::xgmii_width-1:0] m_data,
    output logic [rx_mac_pkg::xgmii_lanes-1:0] m_keep,
    output logic                               m_last,
    output logic                               m_valid
);
    import rx_mac_pkg::*;

    localparam int addr_w  = $clog2(buffer_depth);
    localparam int entry_w = xgmii_width + xgmii_lanes + 1;

    logic [entry_w-1:0] mem [buffer_depth];
    logic [addr_w:0]    wr_ptr;                     // speculative, moves with every write
    logic [addr_w:0]    wr_ptr_next;
    logic [addr_w:0]    commit_ptr;                 // end of the last good frame
    logic [addr_w:0]    rd_ptr;
    logic [addr_w:0]    fill;
    logic               full;
    logic               ovf_flag;
    logic               do_write;
    logic               load;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign fill        = wr_ptr - rd_ptr;
    assign full        = fill[addr_w];              // fill never exceeds the depth
    assign do_write    = wr_en && !full && !ovf_flag;
    assign wr_ptr_next = wr_ptr + {{addr_w{1'b0}}, do_write};
    assign overflow    = ovf_flag || (wr_en && full);

    always_ff @(posedge rx_clk) begin
        if (do_write) begin
            mem[wr_ptr[addr_w-1:0]] <= {wr_last, wr_keep, wr_data};
        end
    end

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            ovf_flag   <= 1'b0;
        end else if (discard) begin
            wr_ptr   <= commit_ptr;                 // rewind over the whole bad frame
            ovf_flag <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr_next;
            if (commit) begin
                commit_ptr <= wr_ptr_next;          // includes a last word written this cycle
                ovf_flag   <= 1'b0;
            end else if (wr_en && full) begin
                ovf_flag <= 1'b1;                   // no more writes until the verdict
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign load = (!m_valid || m_ready) && rd_ptr != commit_ptr;

    always_ff @(posedge rx_clk) begin
        if (!rx_rst) begin
            rd_ptr  <= '0;
            m_valid <= 1'b0;
        end else if (load) begin
            rd_ptr  <= rd_ptr + 1'b1;
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (load) begin
            {m_last, m_keep, m_data} <= mem[rd_ptr[addr_w-1:0]];
        end
    end

    // a stalled word must not change under the consumer
    assert property (@(posedge rx_clk) disable iff (!rx_rst)
        m_valid && !m_ready |=> m_valid && $stable({m_data, m_keep, m_last}))
        else $error("rx_frame_buffer: output word changed while stalled");

endmodule

// File: rx_mac.sv
`timescale 1ns/1ns

module rx_mac #(
    parameter int buffer_depth = 512
) (
    input  logic                               rx_clk,
    input  logic                               rx_rst,
    input  logic [rx_mac_pkg::xgmii_width-1:0] xgmii_data,
    input  logic [rx_mac_pkg::xgmii_lanes-1:0] xgmii_ctl,
    input  logic                               m_ready,
    output logic [rx_mac_pkg::xgmii_width-1:0] m_data,
    output logic [rx_mac_pkg::xgmii_lanes-1:0] m_keep,
    output logic                               m_last,
    output logic                               m_valid,
    output logic                               frame_good,
    output logic                               frame_bad,
    output logic                               crc_error
);
    import rx_mac_pkg::*;

    logic                   dec_valid;
    logic                   dec_start;
    logic [xgmii_width-1:0] dec_data;
    lane_kind_t             dec_kind [xgmii_lanes];

    logic                   crc_clear;
    logic                   crc_en;
    logic [xgmii_width-1:0] crc_data;
    logic [xgmii_lanes-1:0] crc_mask;
    logic                   crc_ok;

    logic                   wr_en;
    logic [xgmii_width-1:0] wr_data;
    logic [xgmii_lanes-1:0] wr_keep;
    logic                   wr_last;
    logic                   commit;
    logic                   discard;
    logic                   overflow;

    xgmii_lane_decode u_decode (
        .rx_clk     (rx_clk),
        .rx_rst     (rx_rst),
        .xgmii_data (xgmii_data),
        .xgmii_ctl  (xgmii_ctl),
        .dec_valid  (dec_valid),
        .dec_start  (dec_start),
        .dec_data   (dec_data),
        .dec_kind   (dec_kind)
    );

    eth_crc32 u_crc (
        .rx_clk    (rx_clk),
        .rx_rst    (rx_rst),
        .crc_clear (crc_clear),
        .crc_en    (crc_en),
        .crc_data  (crc_data),
        .crc_mask  (crc_mask),
        .crc_ok    (crc_ok)
    );

    rx_frame_fsm u_fsm (
        .rx_clk     (rx_clk),
        .rx_rst     (rx_rst),
        .dec_valid  (dec_valid),
        .dec_start  (dec_start),
        .dec_data   (dec_data),
        .dec_kind   (dec_kind),
        .crc_ok     (crc_ok),
        .overflow   (overflow),
        .crc_clear  (crc_clear),
        .crc_en     (crc_en),
        .crc_data   (crc_data),
        .crc_mask   (crc_mask),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .wr_keep    (wr_keep),
        .wr_last    (wr_last),
        .commit     (commit),
        .discard    (discard),
        .frame_good (frame_good),
        .frame_bad  (frame_bad),
        .crc_error  (crc_error)
    );

    rx_frame_buffer #(
        .buffer_depth (buffer_depth)
    ) u_buffer (
        .rx_clk   (rx_clk),
        .rx_rst   (rx_rst),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .wr_keep  (wr_keep),
        .wr_last  (wr_last),
        .commit   (commit),
        .discard  (discard),
        .m_ready  (m_ready),
        .overflow (overflow),
        .m_data   (m_data),
        .m_keep   (m_keep),
        .m_last   (m_last),
        .m_valid  (m_valid)
    );

endmodule

// File: tb_frame_gen.svh
localparam int fault_none = 0;
localparam int fault_flip = 1;                      // one payload bit inverted after the FCS
localparam int fault_sfd  = 2;
localparam int fault_xerr = 3;                      // error character in lane 1 of body column 5

function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

// bit-serial crc over the first n bytes of byte_buf, complemented for the FCS
function automatic logic [31:0] ref_crc(input int n);
    logic [31:0] c;
    c = 32'hffff_ffff;
    for (int i = 0; i < n; i++) begin
        for (int b = 0; b < 8; b++) begin
            if (c[0] ^ byte_buf[i][b]) begin
                c = (c >> 1) ^ 32'hedb8_8320;
            end else begin
                c = c >> 1;
            end
        end
    end
    return ~c;
endfunction

function automatic logic [31:0] keep_bytes(input logic [31:0] d, input logic [3:0] k);
    return d & {{8{k[3]}}, {8{k[2]}}, {8{k[1]}}, {8{k[0]}}};
endfunction

task automatic drive_column(input logic [31:0] data, input logic [3:0] ctl, input logic mark);
    logic [31:0] r;
    @(negedge rx_clk);
    xgmii_data   = data;
    xgmii_ctl    = ctl;
    verdict_mark = mark;                            // verdict due two cycles after this column
    if (ready_random) begin
        r       = next_random();
        m_ready = r[1:0] != 2'b00;
    end
endtask

task automatic send_frame(input int len, input int fault);
    int          nwords;
    int          pos;
    logic [31:0] r;
    logic [31:0] data;
    logic [3:0]  ctl;
    logic [3:0]  keep;
    logic        mark;
    logic        in_range;
    for (int i = 0; i < len - 4; i++) begin
        r           = next_random();
        byte_buf[i] = r[7:0];
    end
    r = ref_crc(len - 4);
    for (int i = 0; i < 4; i++) begin
        byte_buf[len - 4 + i] = r[8*i +: 8];        // FCS goes out low byte first
    end
    if (fault == fault_flip) begin
        byte_buf[len / 2] ^= 8'h08;
    end
    nwords   = (len + 3) / 4;
    in_range = len >= 64 && len <= 1518;
    exp_crc  = fault == fault_flip && in_range;
    exp_good = fault == fault_none && in_range
               && (!stall_count || stall_words + nwords <= buffer_depth);
    if (exp_good) begin
        if (stall_count) begin
            stall_words += nwords;
        end
        for (int w = 0; w < nwords; w++) begin
            data = '0;
            keep = '0;
            for (int j = 0; j < 4; j++) begin
                if (4 * w + j < len) begin
                    data[8*j +: 8] = byte_buf[4 * w + j];
                    keep[j]        = 1'b1;
                end
            end
            exp_q.push_back({w == nwords - 1, keep, data});
        end
    end

    drive_column({{3{preamble_byte}}, xgmii_start}, 4'b0001, 1'b0);
    drive_column({(fault == fault_sfd) ? 8'hd4 : sfd_byte, {3{preamble_byte}}}, 4'b0000,
                 fault == fault_sfd);
    for (int c = 0; c <= len / 4; c++) begin
        for (int j = 0; j < 4; j++) begin
            pos = 4 * c + j;
            if (pos < len) begin
                data[8*j +: 8] = byte_buf[pos];
                ctl[j]         = 1'b0;
            end else begin
                data[8*j +: 8] = (pos == len) ? xgmii_terminate : xgmii_idle;
                ctl[j]         = 1'b1;
            end
        end
        mark = c == len / 4 && fault != fault_sfd && fault != fault_xerr;
        if (fault == fault_xerr && c == 5) begin
            data[15:8] = xgmii_error;
            ctl[1]     = 1'b1;
            mark       = 1'b1;
        end
        drive_column(data, ctl, mark);
    end
    repeat (4) drive_column({4{xgmii_idle}}, 4'hf, 1'b0);
endtask

// File: tb_rx_mac.sv
`timescale 1ns/1ns

module tb_rx_mac;
    import rx_mac_pkg::*;

    localparam int buffer_depth      = 512;
    localparam int random_frames     = 12;
    localparam int frame_bytes_total = 1780 + 200 + 2282 + 3064 + random_frames * 256;
    localparam int frame_count       = 5 + 2 + 8 + 4 + random_frames;
    localparam int budget_cycles     = 4 * (frame_bytes_total / 4 + 8 * frame_count) + 2000;
    localparam int good_lens [5]     = '{64, 65, 66, 67, 1518};

    logic        rx_clk;
    logic        rx_rst;
    logic [31:0] xgmii_data;
    logic [3:0]  xgmii_ctl;
    logic        m_ready;
    logic [31:0] m_data;
    logic [3:0]  m_keep;
    logic        m_last;
    logic        m_valid;
    logic        frame_good;
    logic        frame_bad;
    logic        crc_error;

    logic [7:0]  byte_buf [2048];
    logic [31:0] rng_state;
    logic [36:0] exp_q [$];                         // {last, keep, data} of each expected word
    logic        exp_good;
    logic        exp_crc;
    logic        verdict_mark;
    logic        mark_d1;
    logic        mark_d2;
    logic        head_valid;
    logic [36:0] head_word;
    logic        ready_random;
    logic        stall_count;
    int          stall_words;
    int          err_count;
    int          err_at_start;
    int          tests_passed;
    int          tests_failed;

    `include "tb_frame_gen.svh"

    rx_mac #(
        .buffer_depth (buffer_depth)
    ) u_dut (
        .rx_clk     (rx_clk),
        .rx_rst     (rx_rst),
        .xgmii_data (xgmii_data),
        .xgmii_ctl  (xgmii_ctl),
        .m_ready    (m_ready),
        .m_data     (m_data),
        .m_keep     (m_keep),
        .m_last     (m_last),
        .m_valid    (m_valid),
        .frame_good (frame_good),
        .frame_bad  (frame_bad),
        .crc_error  (crc_error)
    );

    always #50 rx_clk = ~rx_clk;

    always @(posedge rx_clk) begin
        mark_d1 <= verdict_mark;
        mark_d2 <= mark_d1;
    end

    always @(posedge rx_clk) begin
        if (rx_rst && m_valid && m_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        head_valid <= exp_q.size() > 0;             // head shows the word for the next transfer
        if (exp_q.size() > 0) begin
            head_word <= exp_q[0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assert property (@(posedge rx_clk) disable iff (!rx_rst) frame_good == (mark_d2 && exp_good))
        else begin
            err_count++;
            $display("Error: %0t frame_good expected %b got %b", $time,
                     $sampled(mark_d2 && exp_good), $sampled(frame_good));
        end

    assert property (@(posedge rx_clk) disable iff (!rx_rst) frame_bad == (mark_d2 && !exp_good))
        else begin
            err_count++;
            $display("Error: %0t frame_bad expected %b got %b", $time,
                     $sampled(mark_d2 && !exp_good), $sampled(frame_bad));
        end

    assert property (@(posedge rx_clk) disable iff (!rx_rst) crc_error == (mark_d2 && exp_crc))
        else begin
            err_count++;
            $display("Error: %0t crc_error expected %b got %b", $time,
                     $sampled(mark_d2 && exp_crc), $sampled(crc_error));
        end

    assert property (@(posedge rx_clk) disable iff (!rx_rst) m_valid && m_ready |-> head_valid)
        else begin
            err_count++;
            $display("Error: %0t an output word was transferred with no good frame pending", $time);
        end

    assert property (@(posedge rx_clk) disable iff (!rx_rst)
        m_valid && m_ready && head_valid |-> {m_last, m_keep, keep_bytes(m_data, m_keep)} == head_word)
        else begin
            err_count++;
            $display("Error: %0t {m_last,m_keep,m_data} expected %h got %h", $time,
                     $sampled(head_word), $sampled({m_last, m_keep, keep_bytes(m_data, m_keep)}));
        end

    assert property (@(posedge rx_clk) disable iff (!rx_rst)
        m_valid && !m_ready |=> m_valid && $stable({m_data, m_keep, m_last}))
        else begin
            err_count++;
            $display("Error: %0t the output word changed or dropped while m_ready was low", $time);
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_q.size() > 0 || m_valid) && cycles < 4 * buffer_depth + 100) begin
            drive_column({4{xgmii_idle}}, 4'hf, 1'b0);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            err_count++;
            $display("%0t: %0d expected output words were never delivered", $time, exp_q.size());
        end
    endtask

    task automatic finish_test(input string name);
        if (err_count == err_at_start) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, err_count - err_at_start);
        end
        err_at_start = err_count;
    endtask

    initial begin
        #(budget_cycles * 100);
        $display("watchdog: the run did not finish within %0d cycles", budget_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        rx_clk       = 1'b0;
        rx_rst       = 1'b0;
        xgmii_data   = {4{xgmii_idle}};
        xgmii_ctl    = 4'hf;
        m_ready      = 1'b1;
        verdict_mark = 1'b0;
        mark_d1      = 1'b0;
        mark_d2      = 1'b0;
        exp_good     = 1'b0;
        exp_crc      = 1'b0;
        ready_random = 1'b0;
        stall_count  = 1'b0;
        stall_words  = 0;
        rng_state    = 32'hf616_a2bd;
        err_count    = 0;
        err_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(posedge rx_clk);
        @(negedge rx_clk);
        rx_rst = 1'b1;
        repeat (4) drive_column({4{xgmii_idle}}, 4'hf, 1'b0);

        for (int i = 0; i < 5; i++) begin
            send_frame(good_lens[i], fault_none);
        end
        wait_drain();
        finish_test("good lengths");

        send_frame(100, fault_flip);
        send_frame(100, fault_none);
        wait_drain();
        finish_test("crc error");

        send_frame(100, fault_sfd);
        send_frame(100, fault_none);
        send_frame(60, fault_none);
        send_frame(100, fault_none);
        send_frame(1522, fault_none);
        send_frame(100, fault_none);
        send_frame(200, fault_xerr);
        send_frame(100, fault_none);
        wait_drain();
        finish_test("framing errors");

        m_ready     = 1'b0;
        stall_count = 1'b1;
        stall_words = 0;
        send_frame(1000, fault_none);
        send_frame(1000, fault_none);
        send_frame(1000, fault_none);
        send_frame(64, fault_none);
        repeat (20) drive_column({4{xgmii_idle}}, 4'hf, 1'b0);
        m_ready     = 1'b1;
        stall_count = 1'b0;
        wait_drain();
        finish_test("overflow under stall");

        ready_random = 1'b1;
        for (int k = 0; k < random_frames; k++) begin
            r = next_random();
            send_frame(64 + int'(r % 32'd193), fault_none);
        end
        wait_drain();
        ready_random = 1'b0;
        m_ready      = 1'b1;
        finish_test("random back-pressure");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rx_mac.f
+incdir+.
rx_mac_pkg.sv
xgmii_lane_decode.sv
eth_crc32.sv
rx_frame_fsm.sv
rx_frame_buffer.sv
rx_mac.sv
tb_rx_mac.sv

// File: Bender.yml
package:
  name: rx_mac

sources:
  - include_dirs:
      - .
    files:
      - rx_mac_pkg.sv
      - xgmii_lane_decode.sv
      - eth_crc32.sv
      - rx_frame_fsm.sv
      - rx_frame_buffer.sv
      - rx_mac.sv
      - tb_rx_mac.sv
